// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the fetch unit testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ifu -f src.f

# a fatal stop exits nonzero, so the log is searched instead of the exit code
./obj_dir/Vtb_ifu 2>&1 | tee "$LOG"

if grep -q "Test failed" "$LOG"; then
    echo "RESULT: FAIL"
    exit 1
fi
if ! grep -q "Test completed successfully" "$LOG"; then
    echo "RESULT: FAIL, simulation ended without a pass line"
    exit 1
fi
echo "RESULT: PASS"

// ==== src.f ====
+incdir+verilog
verilog/axi_pkg.sv
verilog/ifu_pkg.sv
verilog/ifu_pc_gen.sv
verilog/ifu_ar_stage.sv
verilog/ifu_r_stage.sv
verilog/ifu_top.sv
test/tb_axi_rd_slave.sv
test/ifu_assert.sv
test/tb_ifu.sv

// ==== test/ifu_assert.sv ====
// fetch unit protocol checks
// handshake stability on AR and fetch, rready held under rvalid
`timescale 1ns/10ps
`default_nettype none

module ifu_assert
    import axi_pkg::*;
    import ifu_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input axi_ar_t    ar,
    input logic       arvalid,
    input logic       arready,
    input logic       rvalid,
    input logic       rready,
    input fetch_pkt_t fetch,
    input logic       fetch_valid,
    input logic       fetch_ready
);

    // AR request stays up and unchanged until taken
    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(ar))
        else $error("arvalid or ar changed before arready");

    fetch_hold: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_valid && !fetch_ready |=> fetch_valid && $stable(fetch))
        else $error("fetch packet changed while stalled");

    rready_hold: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(rready) |-> !rvalid)
        else $error("rready fell with rvalid high");

endmodule

bind ifu_top ifu_assert u_ifu_assert (
    .clk         (clk),
    .rst_n       (rst_n),
    .ar          (ar),
    .arvalid     (arvalid),
    .arready     (arready),
    .rvalid      (rvalid),
    .rready      (rready),
    .fetch       (fetch),
    .fetch_valid (fetch_valid),
    .fetch_ready (fetch_ready)
);

`default_nettype wire

// ==== test/tb_axi_rd_slave.sv ====
// AXI read slave model for the fetch unit testbench
// random accept and return delays, data is address xor a fixed pattern
`timescale 1ns/10ps
`default_nettype none
`include "ifu_defines.svh"

module tb_axi_rd_slave
    import axi_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [`IFU_XLEN-1:0] err_addr,   // answered with SLVERR
    input  axi_ar_t              ar,
    input  logic                 arvalid,
    output logic                 arready,
    output axi_r_t               r,
    output logic                 rvalid,
    input  logic                 rready
);

    logic [`IFU_XLEN-1:0] addr_q [$];    // accepted, not yet returned
    int unsigned          delay_q [$];   // cycles left before each beat
    int unsigned          ar_wait;

    function automatic axi_r_t make_beat(input logic [`IFU_XLEN-1:0] addr,
                                         input logic [`IFU_XLEN-1:0] bad);
        axi_r_t beat;
        beat.data = addr ^ 32'ha5a5_0000;
        beat.resp = (addr == bad) ? SLVERR : OKAY;
        beat.last = 1'b1;
        return beat;
    endfunction

    initial begin : drive_proc
        logic                 ar_hs;
        logic                 ar_pend;
        logic                 r_hs;
        logic [`IFU_XLEN-1:0] ar_addr;
        arready = 1'b0;
        rvalid  = 1'b0;
        r       = '0;
        ar_wait = 0;
        forever begin
            @(negedge clk);              // handshakes that complete on the next edge
            ar_hs   = arvalid && arready;
            ar_pend = arvalid && !arready;
            r_hs    = rvalid && rready;
            ar_addr = ar.addr;
            @(posedge clk);
            #10;
            if (!rst_n) begin
                addr_q.delete();
                delay_q.delete();
                arready = 1'b0;
                rvalid  = 1'b0;
                ar_wait = $urandom % 4;
            end else begin
                if (r_hs) begin
                    void'(addr_q.pop_front());
                    void'(delay_q.pop_front());
                    rvalid = 1'b0;
                end
                if (ar_hs) begin
                    addr_q.push_back(ar_addr);
                    delay_q.push_back($urandom % 5);
                    ar_wait = $urandom % 4;
                end else if (ar_pend && ar_wait != 0) begin
                    ar_wait = ar_wait - 1;
                end
                arready = (ar_wait == 0);
                // in order return, head beat counts down first
                if (!rvalid && addr_q.size() != 0) begin
                    if (delay_q[0] == 0) begin
                        r      = make_beat(addr_q[0], err_addr);
                        rvalid = 1'b1;
                    end else begin
                        delay_q[0] = delay_q[0] - 1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== test/tb_ifu.sv ====
// fetch unit testbench
// table driven enable and stall patterns, in order fetch checking
`timescale 1ns/10ps
`default_nettype none
`include "ifu_defines.svh"

module tb_ifu
    import axi_pkg::*;
    import ifu_pkg::*;
;

    typedef struct packed {
        int unsigned en_cycles;   // enable high time
        int unsigned duty;        // fetch_ready high, percent
        logic [31:0] err_ofs;     // error address as offset from the row's first fetch address
        int unsigned min_fetch;   // throughput floor for the row
    } row_t;

    localparam int   NUM_ROWS = 5;
    localparam row_t ROWS [NUM_ROWS] = '{
        '{60,  100, 32'h0000_0010, 6},
        '{80,  30,  32'h0000_0020, 4},
        '{50,  100, 32'h0000_0000, 5},
        '{100, 10,  32'h0000_0008, 3},   // heavy stall
        '{40,  60,  32'h0004_0000, 3}    // error address never reached
    };

    logic                 clk;
    logic                 rst_n;
    logic                 enable;
    axi_ar_t              ar;
    logic                 arvalid;
    logic                 arready;
    axi_r_t               r;
    logic                 rvalid;
    logic                 rready;
    fetch_pkt_t           fetch;
    logic                 fetch_valid;
    logic                 fetch_ready;
    logic [`IFU_XLEN-1:0] err_addr;

    pc_t         exp_pc;
    int unsigned duty_cur;
    int unsigned row_fetches;

    ifu_top u_ifu_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .enable      (enable),
        .ar          (ar),
        .arvalid     (arvalid),
        .arready     (arready),
        .r           (r),
        .rvalid      (rvalid),
        .rready      (rready),
        .fetch       (fetch),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready)
    );

    tb_axi_rd_slave u_slave (
        .clk      (clk),
        .rst_n    (rst_n),
        .err_addr (err_addr),
        .ar       (ar),
        .arvalid  (arvalid),
        .arready  (arready),
        .r        (r),
        .rvalid   (rvalid),
        .rready   (rready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ----------------------------------------
    // failure handling and compares
    // ----------------------------------------
    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic compare_pc(input string name, input pc_t got, input pc_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_inst(input string name, input inst_t got, input inst_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    // ----------------------------------------
    // checker samples mid cycle
    // ----------------------------------------
    always @(negedge clk) begin : check_proc
        pc_t   addr;
        inst_t exp_inst;
        logic  exp_err;
        if (rst_n && fetch_valid && fetch_ready) begin
            addr     = `IFU_MEM_BASE + exp_pc;
            exp_inst = addr ^ 32'ha5a5_0000;    // slave word rule
            exp_err  = (addr == err_addr);
            compare_pc("fetch.pc", fetch.pc, exp_pc);
            compare_inst("fetch.inst", fetch.inst, exp_inst);
            compare_flag("fetch.err", fetch.err, exp_err);
            exp_pc = exp_pc + `IFU_PC_STEP;
            row_fetches++;
        end
    end

    // consumer stall pattern
    always @(posedge clk) begin : ready_proc
        #10;
        fetch_ready = rst_n && (($urandom % 100) < duty_cur);
    end

    task automatic run_row(input int idx);
        row_t row;
        int   low_cycles;
        row = ROWS[idx];
        @(posedge clk);
        #10;
        err_addr    = `IFU_MEM_BASE + exp_pc + row.err_ofs;
        duty_cur    = row.duty;
        row_fetches = 0;
        enable      = 1'b1;
        repeat (row.en_cycles) @(posedge clk);
        #10;
        enable = 1'b0;
        low_cycles = 0;
        while (low_cycles < 20) begin      // drained once fetch_valid stays quiet
            @(negedge clk);
            if (fetch_valid) begin
                low_cycles = 0;
            end else begin
                low_cycles++;
            end
        end
        if (row_fetches < row.min_fetch) begin
            $display("row %0d produced only %0d fetches, at least %0d were expected",
                     idx, row_fetches, row.min_fetch);
            abort_run();
        end
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin : main_proc
        void'($urandom(32'hc7cd_6b8d));
        rst_n       = 1'b0;
        enable      = 1'b0;
        fetch_ready = 1'b0;
        err_addr    = 32'hffff_fffc;
        duty_cur    = 0;
        row_fetches = 0;
        exp_pc      = `IFU_BOOT_PC;
        repeat (8) @(posedge clk);
        #10;
        rst_n = 1'b1;
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        $display("Test completed successfully");
        $finish;
    end

    // budget is reset plus enable time plus 200 cycles per row
    initial begin : watchdog_proc
        int unsigned limit;
        limit = 8 + 200 * NUM_ROWS;
        for (int i = 0; i < NUM_ROWS; i++) begin
            limit = limit + ROWS[i].en_cycles;
        end
        repeat (limit) @(posedge clk);
        $display("watchdog expired after %0d cycles without finishing", limit);
        $display("Test failed");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

// ==== verilog/axi_pkg.sv ====
// AXI4 read channel types for the fetch master
// single beat reads, id 0, fixed attributes
`default_nettype none
`include "ifu_defines.svh"

package axi_pkg;

    // response code, bit 1 flags an error
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    // AR payload, qualified by arvalid
    typedef struct packed {
        logic [`IFU_XLEN-1:0] addr;
    } axi_ar_t;

    // R payload, qualified by rvalid
    typedef struct packed {
        logic [`IFU_XLEN-1:0] data;
        axi_resp_e            resp;
        logic                 last;   // always set for single beat
    } axi_r_t;

endpackage

`default_nettype wire

// ==== verilog/ifu_ar_stage.sv ====
// fetch address stage
// drives the AXI AR channel and tracks outstanding reads by credits
`timescale 1ns/10ps
`default_nettype none
`include "ifu_defines.svh"

module ifu_ar_stage
    import axi_pkg::*;
    import ifu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    // request from pc stage
    input  logic       req_valid,
    input  fetch_req_t req,
    output logic       req_ready,
    // AXI read address channel
    output axi_ar_t    ar,
    output logic       arvalid,
    input  logic       arready,
    // bookkeeping with the response stage
    input  logic       retire,
    output logic       issue,
    output pc_t        issue_pc
);

    localparam logic [`IFU_CNT_W-1:0] MAX_CREDIT = `IFU_CNT_W'(`IFU_MAX_OUTSTANDING);

    logic [`IFU_CNT_W-1:0] credit_cnt;   // reads issued and not yet retired
    logic                  req_fire;
    pc_t                   ar_pc;        // pc behind the address on AR

    // no new request while AR is busy, so the count is exact at accept
    assign req_ready = (credit_cnt != MAX_CREDIT) && !arvalid;
    assign req_fire  = req_valid & req_ready;

    assign issue    = arvalid & arready;
    assign issue_pc = ar_pc;

    // ----------------------------------------
    // AR channel
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arvalid <= 1'b0;
        end else if (req_fire) begin
            arvalid <= 1'b1;
        end else if (issue) begin
            arvalid <= 1'b0;
        end
    end

    // address and pc only load on accept, held until arready
    always_ff @(posedge clk) begin
        if (req_fire) begin
            ar.addr <= `IFU_MEM_BASE + req.pc;
            ar_pc   <= req.pc;
        end
    end

    // ----------------------------------------
    // read credits
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_cnt <= '0;
        end else begin
            case ({issue, retire})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;   // none or both
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ifu_defines.svh ====
// fetch unit shared parameters
// widths, boot pc, memory window and read credit depth
`ifndef IFU_DEFINES_SVH
`define IFU_DEFINES_SVH

// datapath and address width
`define IFU_XLEN            32

// program counter
`define IFU_BOOT_PC         32'h0000_0000   // pc out of reset
`define IFU_PC_STEP         32'd4           // one rv32 word

// pc to bus address offset
`define IFU_MEM_BASE        32'h0000_1000

// reads in flight, also the depth of both response queues
`define IFU_MAX_OUTSTANDING 2

// credit and queue counters, must hold IFU_MAX_OUTSTANDING
`define IFU_CNT_W           2

`endif

// ==== verilog/ifu_pc_gen.sv ====
// fetch pc stage
// holds the program counter and offers fetch requests downstream
`timescale 1ns/10ps
`default_nettype none
`include "ifu_defines.svh"

module ifu_pc_gen
    import ifu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       enable,     // fetch enable from core control
    input  logic       req_ready,
    output logic       req_valid,
    output fetch_req_t req
);

    pc_t  pc;
    logic req_fire;

    assign req_fire = req_valid & req_ready;

    // ----------------------------------------
    // program counter
    // ----------------------------------------
    // sequential only, next pc is always pc + step
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `IFU_BOOT_PC;
        end else if (req_fire) begin
            pc <= pc + `IFU_PC_STEP;
        end
    end

    // ----------------------------------------
    // request flag
    // ----------------------------------------
    // a raised request stays up until taken, enable only gates new ones
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_valid <= 1'b0;
        end else if (req_fire || !req_valid) begin
            req_valid <= enable;
        end
    end

    assign req.pc = pc;   // stable while waiting, pc moves only on fire

endmodule

`default_nettype wire

// ==== verilog/ifu_pkg.sv ====
// fetch side types
// pc, instruction word, fetch request and decoder packet
`default_nettype none
`include "ifu_defines.svh"

package ifu_pkg;

    typedef logic [`IFU_XLEN-1:0] pc_t;
    typedef logic [`IFU_XLEN-1:0] inst_t;

    // request from pc stage to address stage
    typedef struct packed {
        pc_t pc;
    } fetch_req_t;

    // packet handed to the decoder
    typedef struct packed {
        pc_t   pc;
        inst_t inst;
        logic  err;    // bus error on this fetch
    } fetch_pkt_t;

endpackage

`default_nettype wire

// ==== verilog/ifu_r_stage.sv ====
// fetch response stage
// pairs R beats with issued pcs and presents fetch packets in order
`timescale 1ns/10ps
`default_nettype none
`include "ifu_defines.svh"

module ifu_r_stage
    import axi_pkg::*;
    import ifu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    // issued pcs from the address stage
    input  logic       issue,
    input  pc_t        issue_pc,
    // AXI read data channel
    input  axi_r_t     r,
    input  logic       rvalid,
    output logic       rready,
    // decoder side
    output fetch_pkt_t fetch,
    output logic       fetch_valid,
    input  logic       fetch_ready,
    output logic       retire
);

    localparam int DEPTH = `IFU_MAX_OUTSTANDING;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [`IFU_CNT_W-1:0] FULL      = `IFU_CNT_W'(DEPTH);
    localparam logic [PTR_W-1:0]      LAST_SLOT = PTR_W'(DEPTH - 1);

    // queue storage
    pc_t   pc_q   [DEPTH];
    inst_t inst_q [DEPTH];
    logic  err_q  [DEPTH];

    logic [PTR_W-1:0]      pc_wr_ptr;
    logic [PTR_W-1:0]      dat_wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;      // both queues pop together
    logic [`IFU_CNT_W-1:0] pc_cnt;
    logic [`IFU_CNT_W-1:0] dat_cnt;
    logic [`IFU_CNT_W-1:0] dat_cnt_nxt;
    logic                  r_fire;
    logic                  pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        ptr_inc = (p == LAST_SLOT) ? '0 : p + 1'b1;
    endfunction

    assign r_fire = rvalid & rready;

    // ----------------------------------------
    // output side
    // ----------------------------------------
    assign fetch_valid = (pc_cnt != '0) && (dat_cnt != '0);
    assign pop         = fetch_valid & fetch_ready;
    assign retire      = pop;    // returns one credit

    assign fetch.pc   = pc_q[rd_ptr];
    assign fetch.inst = inst_q[rd_ptr];
    assign fetch.err  = err_q[rd_ptr];

    // ----------------------------------------
    // queue writes
    // ----------------------------------------
    // pc always lands before its data, AR precedes R
    always_ff @(posedge clk) begin
        if (issue) begin
            pc_q[pc_wr_ptr] <= issue_pc;
        end
        if (r_fire) begin
            inst_q[dat_wr_ptr] <= r.data;
            err_q[dat_wr_ptr]  <= r.resp[1];   // SLVERR or DECERR
        end
    end

    assign dat_cnt_nxt = dat_cnt + `IFU_CNT_W'(r_fire) - `IFU_CNT_W'(pop);

    // ----------------------------------------
    // pointers and counts
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_wr_ptr  <= '0;
            dat_wr_ptr <= '0;
            rd_ptr     <= '0;
            pc_cnt     <= '0;
            dat_cnt    <= '0;
            rready     <= 1'b0;
        end else begin
            if (issue) begin
                pc_wr_ptr <= ptr_inc(pc_wr_ptr);
            end
            if (r_fire) begin
                dat_wr_ptr <= ptr_inc(dat_wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            pc_cnt  <= pc_cnt + `IFU_CNT_W'(issue) - `IFU_CNT_W'(pop);
            dat_cnt <= dat_cnt_nxt;
            rready  <= (dat_cnt_nxt != FULL);   // credits keep this high
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ifu_top.sv ====
// instruction fetch unit top
// pc stage, AXI address stage and response stage in a pipeline
`timescale 1ns/10ps
`default_nettype none

module ifu_top
    import axi_pkg::*;
    import ifu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       enable,
    // AXI read master
    output axi_ar_t    ar,
    output logic       arvalid,
    input  logic       arready,
    input  axi_r_t     r,
    input  logic       rvalid,
    output logic       rready,
    // fetch output to decoder
    output fetch_pkt_t fetch,
    output logic       fetch_valid,
    input  logic       fetch_ready
);

    fetch_req_t req;
    logic       req_valid;
    logic       req_ready;
    logic       issue;
    pc_t        issue_pc;
    logic       retire;

    ifu_pc_gen u_pc_gen (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (enable),
        .req_ready (req_ready),
        .req_valid (req_valid),
        .req       (req)
    );

    ifu_ar_stage u_ar_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .ar        (ar),
        .arvalid   (arvalid),
        .arready   (arready),
        .retire    (retire),
        .issue     (issue),
        .issue_pc  (issue_pc)
    );

    ifu_r_stage u_r_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue       (issue),
        .issue_pc    (issue_pc),
        .r           (r),
        .rvalid      (rvalid),
        .rready      (rready),
        .fetch       (fetch),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .retire      (retire)
    );

endmodule

`default_nettype wire
